// File: project.f
+incdir+logic
logic/wbs_pkg.sv
logic/wbs_decode.sv
logic/wbs_mem.sv
logic/wbs_io_regs.sv
logic/wbs_top.sv
verification/wbs_asserts.sv
verification/wbs_tb.sv

// File: Makefile
# Verilator build and run for the wishbone slave subsystem

VERILATOR ?= verilator
TOP       ?= wbs_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/wbs_tb.sv
// wishbone slave subsystem testbench
// random bus master against a shadow model of ram, registers and scan

`timescale 1ns/100ps

`include "wbs_defines.svh"

module wbs_tb;

   import wbs_pkg::*;

   localparam int n_mem     = 40;                  // write/read pairs
   localparam int n_lane    = 40;                  // byte lane rounds, 3 xfers each
   localparam int n_io      = 30;                  // i/o rounds, 4 xfers each
   localparam int n_scan    = 3 * `WBS_SCAN_DIV * `WBS_DIGITS;
   localparam int xfers     = 2 * n_mem + 3 * n_lane + 4 * n_io + 3;
   localparam int wd_cycles = 2 * (6 * xfers + n_scan + 80);  // x2 margin
   localparam int max_wait  = 16;                  // ack wait per transfer
   localparam logic [`WBS_DIGITS-1:0] one_digit = 1;
   localparam logic [`WBS_DIGITS-1:0] idle_hsel = ~one_digit;

   logic                   wb_clk;
   logic                   rst_n_i;
   wb_req_t                req;                    // master request
   logic [3:0]             btn;
   wb_rsp_t                rsp;
   logic [7:0]             hex;
   logic [`WBS_DIGITS-1:0] hsel;

   logic [15:0] sh_ram [1 << `WBS_MEM_AW];         // ram shadow
   logic [15:0] sh_disp0;
   logic [15:0] sh_disp1;
   logic [3:0]  sh_btn;
   int          m_presc;                           // prescaler model
   int          m_idx;                             // scan index model
   integer      seed = 32'hbee;
   int          n_checks = 0;
   int          n_err = 0;

   wbs_top u_wbs_top
   (
      .wb_clk   (wb_clk),
      .rst_n_i  (rst_n_i),
      .wb_req_i (req),
      .btn_i    (btn),
      .wb_rsp_o (rsp),
      .hex_o    (hex),
      .hsel_o   (hsel)
   );

   bind wbs_top wbs_asserts u_asserts
   (
      .wb_clk   (wb_clk),
      .rst_n_i  (rst_n_i),
      .wb_req_i (wb_req_i),
      .wb_rsp_i (wb_rsp_o),
      .hsel_i   (hsel_o)
   );

   always #2 wb_clk = ~wb_clk;                     // 4 ns period

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      n_checks++;
      if (got !== exp)
      begin
         n_err++;
         $display("ERR at %0t: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      $display("test %s finished, %0d checks, %0d errors so far", name, n_checks, n_err);
   endtask

   // digit pattern for one scan index
   function automatic logic [7:0] scan_byte(input int idx);
      case (idx)
         0:       return ~sh_disp0[7:0];
         1:       return ~sh_disp0[15:8];
         2:       return ~sh_disp1[7:0];
         3:       return ~sh_disp1[15:8];
         default: return 8'hFF;                    // blank
      endcase
   endfunction

   // prescaler and index model, counts down with wrap
   always @(posedge wb_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         m_presc <= 0;
         m_idx   <= 0;
      end
      else if (m_presc == `WBS_SCAN_DIV - 1)
      begin
         m_presc <= 0;
         m_idx   <= (m_idx == 0) ? `WBS_DIGITS - 1 : m_idx - 1;
      end
      else
      begin
         m_presc <= m_presc + 1;
      end
   end

   // every cycle, values settled from the previous cycle
   always @(posedge wb_clk)
   begin
      logic [`WBS_DIGITS-1:0] exp_hsel;
      exp_hsel = ~(one_digit << m_idx);
      if (rst_n_i)
      begin
         check_val("hsel_o", 32'(hsel), 32'(exp_hsel));
         check_val("hex_o", 32'(hex), 32'(scan_byte(m_idx)));
      end
   end

   // drive one transfer, return at the negedge where ack is seen
   task automatic bus_cycle(input logic [15:0] adr, input logic we, input logic [1:0] sel,
                            input logic [15:0] dat, output logic [15:0] rdat,
                            output int lat);
      @(posedge wb_clk);
      req.adr <= adr;
      req.dat <= dat;
      req.we  <= we;
      req.sel <= sel;
      req.cyc <= 1'b1;
      req.stb <= 1'b1;
      @(negedge wb_clk);
      lat = 0;                                     // edges after the strobe
      while (!rsp.ack && lat < max_wait)
      begin
         @(negedge wb_clk);
         lat++;
      end
      if (!rsp.ack)
      begin
         n_err++;
         $display("no ack for address %h within %0d cycles at %0t", adr, max_wait, $time);
      end
      rdat = rsp.dat;
   endtask

   task automatic bus_idle();
      @(posedge wb_clk);
      req.cyc <= 1'b0;
      req.stb <= 1'b0;
      req.we  <= 1'b0;
   endtask

   task automatic write_mem(input logic [`WBS_MEM_AW-1:0] word, input logic [1:0] sel,
                            input logic [15:0] dat);
      logic [15:0] rdat;
      int          lat;
      bus_cycle({{(15 - `WBS_MEM_AW){1'b0}}, word, 1'b0}, 1'b1, sel, dat, rdat, lat);
      check_val("mem wb_rsp_o.ack delay", 32'(lat), 0);
      if (sel[0]) sh_ram[word][7:0] = dat[7:0];     // lane update
      if (sel[1]) sh_ram[word][15:8] = dat[15:8];
      bus_idle();
   endtask

   task automatic read_mem(input logic [`WBS_MEM_AW-1:0] word);
      logic [15:0] rdat;
      int          lat;
      bus_cycle({{(15 - `WBS_MEM_AW){1'b0}}, word, 1'b0}, 1'b0, 2'b11, 16'h0000, rdat, lat);
      check_val("mem wb_rsp_o.ack delay", 32'(lat), 2);
      check_val("mem wb_rsp_o.dat", 32'(rdat), 32'(sh_ram[word]));
      bus_idle();
   endtask

   task automatic write_io(input logic [1:0] idx, input logic [15:0] dat);
      logic [15:0] rdat;
      int          lat;
      bus_cycle({`WBS_IO_PAGE, idx, 1'b0}, 1'b1, 2'b11, dat, rdat, lat);
      check_val("io wb_rsp_o.ack delay", 32'(lat), 1);
      if (idx == 2'd0) sh_disp0 = dat;
      if (idx == 2'd1) sh_disp1 = dat;              // index 2 read only
      bus_idle();
   endtask

   task automatic read_io(input logic [1:0] idx, input logic [15:0] exp);
      logic [15:0] rdat;
      int          lat;
      bus_cycle({`WBS_IO_PAGE, idx, 1'b0}, 1'b0, 2'b11, 16'h0000, rdat, lat);
      check_val("io wb_rsp_o.ack delay", 32'(lat), 1);
      check_val("io wb_rsp_o.dat", 32'(rdat), 32'(exp));
      bus_idle();
   endtask

   initial
   begin
      #(wd_cycles * 4);
      $display("run timed out at %0t before all tests had finished", $time);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      logic [31:0]            rnd;
      logic [`WBS_MEM_AW-1:0] word;
      logic [1:0]             idx;
      int                     i;
      wb_clk   = 1'b0;
      rst_n_i  = 1'b0;
      req      = '0;
      btn      = 4'h0;
      sh_disp0 = 16'h0000;
      sh_disp1 = 16'h0000;
      sh_btn   = 4'h0;
      repeat (4) @(posedge wb_clk);
      rst_n_i <= 1'b1;

      for (i = 0; i < n_mem; i++)
      begin
         rnd  = $random(seed);
         word = rnd[`WBS_MEM_AW-1:0];
         rnd  = $random(seed);
         write_mem(word, 2'b11, rnd[15:0]);
         read_mem(word);
      end
      report_test("ram write then read");

      for (i = 0; i < n_lane; i++)
      begin
         rnd  = $random(seed);
         word = rnd[`WBS_MEM_AW-1:0];
         write_mem(word, 2'b11, rnd[31:16]);       // known word first
         rnd  = $random(seed);
         write_mem(word, rnd[17:16], rnd[15:0]);   // random lanes
         read_mem(word);
      end
      report_test("byte lanes");

      for (i = 0; i < n_io; i++)
      begin
         rnd = $random(seed);
         @(posedge wb_clk);
         btn   <= rnd[23:20];
         sh_btn = rnd[23:20];
         idx    = (rnd[17:16] == 2'd3) ? 2'd2 : rnd[17:16];
         write_io(idx, rnd[15:0]);
         read_io(2'd0, sh_disp0);
         read_io(2'd1, sh_disp1);
         read_io(2'd2, {12'h000, sh_btn});
      end
      report_test("io registers");

      repeat (n_scan) @(posedge wb_clk);           // scan checker runs alone
      report_test("scan driver");

      // ram read held through the reset, its ack has to drop
      @(posedge wb_clk);
      req.adr <= 16'h0000;
      req.we  <= 1'b0;
      req.sel <= 2'b11;
      req.cyc <= 1'b1;
      req.stb <= 1'b1;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      check_val("wb_rsp_o.ack", 32'(rsp.ack), 1);  // acked before the reset
      while (m_idx < 2)
      begin
         @(negedge wb_clk);                        // scan well away from digit 0
      end
      @(posedge wb_clk);
      rst_n_i <= 1'b0;
      repeat (3) @(posedge wb_clk);
      @(negedge wb_clk);
      sh_disp0 = 16'h0000;
      sh_disp1 = 16'h0000;
      @(posedge wb_clk);
      rst_n_i <= 1'b1;
      @(negedge wb_clk);
      check_val("wb_rsp_o.ack", 32'(rsp.ack), 0);  // stb still held here
      check_val("hsel_o after reset", 32'(hsel), 32'(idle_hsel));
      bus_idle();
      read_io(2'd0, 16'h0000);
      read_io(2'd1, 16'h0000);
      report_test("reset");

      $display("total checks %0d, errors %0d", n_checks, n_err);
      if (n_err == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: verification/wbs_asserts.sv
// bus protocol and display checks for the slave subsystem
// bound to the subsystem top

`timescale 1ns/100ps

`include "wbs_defines.svh"

module wbs_asserts
(
   input logic                   wb_clk,      // bus clock
   input logic                   rst_n_i,     // async reset, active low
   input wbs_pkg::wb_req_t       wb_req_i,    // master request
   input wbs_pkg::wb_rsp_t       wb_rsp_i,    // merged response
   input logic [`WBS_DIGITS-1:0] hsel_i       // digit select
);

   logic bus_act;                             // cyc and stb
   logic rd_act;                              // read in progress

   assign bus_act = wb_req_i.cyc & wb_req_i.stb;
   assign rd_act  = bus_act & ~wb_req_i.we;

   // no ack outside a strobed cycle
   ack_in_cycle: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      wb_rsp_i.ack |-> bus_act)
      else $error("ack high without cyc and stb");

   // exactly one digit driven low
   hsel_one_cold: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      $onehot(~hsel_i))
      else $error("digit select not one cold: %b", hsel_i);

   // read ack never in the first strobe cycle
   read_ack_late: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
      $rose(rd_act) |-> !wb_rsp_i.ack)
      else $error("read ack in the same cycle as the rising strobe");

endmodule

// File: logic/wbs_top.sv
// wishbone slave subsystem top
// decoder in front of the ram slave and the i/o register slave

`timescale 1ns/100ps

`include "wbs_defines.svh"

module wbs_top
(
   input  logic                   wb_clk,    // bus clock
   input  logic                   rst_n_i,   // async reset, active low
   input  wbs_pkg::wb_req_t       wb_req_i,  // request from the master
   input  logic [3:0]             btn_i,     // push buttons
   output wbs_pkg::wb_rsp_t       wb_rsp_o,  // merged response
   output logic [7:0]             hex_o,     // segment pattern
   output logic [`WBS_DIGITS-1:0] hsel_o     // digit select
);

   import wbs_pkg::*;

   logic    mem_stb;                      // ram strobe from decoder
   logic    io_stb;                       // i/o strobe from decoder
   wb_rsp_t mem_rsp;                      // ram response
   wb_rsp_t io_rsp;                       // i/o response

   // address decode and response merge
   wbs_decode u_decode
   (
      .wb_req_i  (wb_req_i),
      .mem_rsp_i (mem_rsp),
      .io_rsp_i  (io_rsp),
      .mem_stb_o (mem_stb),
      .io_stb_o  (io_stb),
      .wb_rsp_o  (wb_rsp_o)
   );

   // 8K x 16 ram at 0x0000
   wbs_mem u_mem
   (
      .wb_clk    (wb_clk),
      .rst_n_i   (rst_n_i),
      .wb_req_i  (wb_req_i),
      .stb_i     (mem_stb),
      .wb_rsp_o  (mem_rsp)
   );

   // display and buttons at 0xFFC0
   wbs_io_regs u_io
   (
      .wb_clk    (wb_clk),
      .rst_n_i   (rst_n_i),
      .wb_req_i  (wb_req_i),
      .stb_i     (io_stb),
      .btn_i     (btn_i),
      .wb_rsp_o  (io_rsp),
      .hex_o     (hex_o),
      .hsel_o    (hsel_o)
   );

endmodule

// File: logic/wbs_io_regs.sv
// wishbone i/o slave, two display registers and a button port
// also drives the six digit seven segment scan

`timescale 1ns/100ps

`include "wbs_defines.svh"

module wbs_io_regs
(
   input  logic                   wb_clk,    // bus clock
   input  logic                   rst_n_i,   // async reset, active low
   input  wbs_pkg::wb_req_t       wb_req_i,  // shared master request
   input  logic                   stb_i,     // decoded strobe, includes cyc
   input  logic [3:0]             btn_i,     // push buttons
   output wbs_pkg::wb_rsp_t       wb_rsp_o,  // data and ack to decoder
   output logic [7:0]             hex_o,     // segment pattern, active low
   output logic [`WBS_DIGITS-1:0] hsel_o     // digit select, one cold
);

   localparam int presc_w = $clog2(`WBS_SCAN_DIV);
   localparam int idx_w   = $clog2(`WBS_DIGITS);
   localparam logic [presc_w-1:0]     presc_last = presc_w'(`WBS_SCAN_DIV - 1);
   localparam logic [idx_w-1:0]       idx_top    = idx_w'(`WBS_DIGITS - 1);
   localparam logic [`WBS_DIGITS-1:0] digit_one  = 1;

   logic [15:0]        disp0;             // display register 0
   logic [15:0]        disp1;             // display register 1
   logic               ack;               // registered ack pulse
   logic               wr_en;             // write on the ack edge
   logic [1:0]         reg_idx;           // register index
   logic [presc_w-1:0] presc;             // scan prescaler
   logic               tick;              // last prescaler count
   logic [idx_w-1:0]   scan_idx;          // current digit

   assign reg_idx = wb_req_i.adr[2:1];
   assign wr_en   = stb_i & wb_req_i.we & ~ack;

   // single ack pulse one clock after stb, then registers
   always_ff @(posedge wb_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         ack   <= 1'b0;
         disp0 <= 16'h0000;
         disp1 <= 16'h0000;
      end
      else
      begin
         ack <= stb_i & ~ack;             // drops in the held cycle
         if (wr_en && reg_idx == 2'd0) disp0 <= wb_req_i.dat;  // whole word
         if (wr_en && reg_idx == 2'd1) disp1 <= wb_req_i.dat;
         // index 2 is read only, 3 has nothing
      end
   end

   // read mux, valid while the address is held
   always_comb
   begin
      case (reg_idx)
         2'd0:    wb_rsp_o.dat = disp0;
         2'd1:    wb_rsp_o.dat = disp1;
         2'd2:    wb_rsp_o.dat = {12'h000, btn_i};  // buttons in low nibble
         default: wb_rsp_o.dat = 16'h0000;
      endcase
   end
   assign wb_rsp_o.ack = ack;

   assign tick = (presc == presc_last);

   // prescaler 0..div-1, digit index steps down and wraps
   always_ff @(posedge wb_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         presc    <= '0;
         scan_idx <= '0;
      end
      else
      begin
         presc <= tick ? '0 : presc + 1'b1;
         if (tick)
         begin
            scan_idx <= (scan_idx == '0) ? idx_top : scan_idx - 1'b1;
         end
      end
   end

   // segments are active low, hence the inversion
   always_comb
   begin
      case (scan_idx)
         3'd0:    hex_o = ~disp0[7:0];
         3'd1:    hex_o = ~disp0[15:8];
         3'd2:    hex_o = ~disp1[7:0];
         3'd3:    hex_o = ~disp1[15:8];
         default: hex_o = 8'hFF;          // blank digits
      endcase
   end

   assign hsel_o = ~(digit_one << scan_idx);   // low only at the current digit

endmodule

// File: logic/wbs_mem.sv
// wishbone ram slave, 8K x 16 with byte lane writes
// writes ack at once, reads ack two clocks after the strobe

`timescale 1ns/100ps

`include "wbs_defines.svh"

module wbs_mem
(
   input  logic             wb_clk,       // bus clock
   input  logic             rst_n_i,      // async reset, active low
   input  wbs_pkg::wb_req_t wb_req_i,     // shared master request
   input  logic             stb_i,        // decoded strobe, includes cyc
   output wbs_pkg::wb_rsp_t wb_rsp_o      // data and ack to decoder
);

   localparam int mem_words = 1 << `WBS_MEM_AW;

   logic [15:0]            ram [mem_words]; // block ram, no reset
   logic [`WBS_MEM_AW-1:0] word_adr;        // word index
   logic                   wr_stb;          // write transfer
   logic                   rd_stb;          // read transfer
   logic [1:0]             rd_ack;          // read ack pipeline
   logic [15:0]            rd_dat;          // registered ram output

   // byte address to word index, bit 0 is the lane
   assign word_adr = wb_req_i.adr[`WBS_MEM_AW:1];

   assign wr_stb = stb_i & wb_req_i.we;
   assign rd_stb = stb_i & ~wb_req_i.we;

   // write port, one enable per byte lane
   always_ff @(posedge wb_clk)
   begin
      if (wr_stb & wb_req_i.sel[0])
      begin
         ram[word_adr][7:0] <= wb_req_i.dat[7:0];    // low lane
      end
      if (wr_stb & wb_req_i.sel[1])
      begin
         ram[word_adr][15:8] <= wb_req_i.dat[15:8];  // high lane
      end
   end

   // synchronous read, whole word whatever sel says
   always_ff @(posedge wb_clk)
   begin
      rd_dat <= ram[word_adr];
   end

   // strobe delayed twice
   // second stage also needs stb so a fresh read never sees a stale bit
   always_ff @(posedge wb_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_ack <= 2'b00;
      end
      else
      begin
         rd_ack[0] <= rd_stb;
         rd_ack[1] <= rd_stb & rd_ack[0];
      end
   end

   // write: same cycle, read: third cycle of the strobe
   // stays high while the master holds stb
   assign wb_rsp_o.ack = stb_i & (wb_req_i.we | rd_ack[1]);
   assign wb_rsp_o.dat = rd_dat;        // valid from the second cycle on

endmodule

// File: logic/wbs_decode.sv
// wishbone address decoder
// selects ram or i/o slave, merges read data and acks

`timescale 1ns/100ps

`include "wbs_defines.svh"

module wbs_decode
(
   input  wbs_pkg::wb_req_t wb_req_i,     // shared master request
   input  wbs_pkg::wb_rsp_t mem_rsp_i,    // ram slave response
   input  wbs_pkg::wb_rsp_t io_rsp_i,     // i/o slave response
   output logic             mem_stb_o,    // ram slave strobe
   output logic             io_stb_o,     // i/o slave strobe
   output wbs_pkg::wb_rsp_t wb_rsp_o      // merged response to master
);

   import wbs_pkg::*;

   wb_adr_u adr;                          // address, two views
   logic    bus_act;                      // cyc and stb both high
   logic    mem_hit;                      // address in ram region
   logic    io_hit;                       // address in i/o page

   assign adr     = wb_req_i.adr;
   assign bus_act = wb_req_i.cyc & wb_req_i.stb;

   // ram view: region field zero means 0x0000..0x3FFF
   assign mem_hit = (adr.mem.region == '0);

   // i/o view: upper 13 bits against the page constant
   assign io_hit  = (adr.io.page == `WBS_IO_PAGE);

   assign mem_stb_o = bus_act & mem_hit;
   assign io_stb_o  = bus_act & io_hit;  // page lies outside region 0, no overlap

   // read data from the strobed slave only
   always_comb
   begin
      wb_rsp_o.dat = 16'h0000;            // nothing selected
      if (mem_stb_o)
      begin
         wb_rsp_o.dat = mem_rsp_i.dat;
      end
      else if (io_stb_o)
      begin
         wb_rsp_o.dat = io_rsp_i.dat;
      end
   end

   // each slave acks only under its own strobe
   // so a plain or is enough
   assign wb_rsp_o.ack = mem_rsp_i.ack | io_rsp_i.ack;

   // unmapped addresses get no ack at all
   // the master would wait forever there

endmodule

// File: logic/wbs_pkg.sv
// wishbone bus types shared by the slave subsystem
// request and response bundles plus the decoded address views

`include "wbs_defines.svh"

package wbs_pkg;

   // master to slave, held steady until ack
   typedef struct packed {
      logic [15:0] adr;                   // byte address
      logic [15:0] dat;                   // write data
      logic        we;                    // 1 = write
      logic [1:0]  sel;                   // byte lanes, [1] high byte
      logic        cyc;                   // bus cycle in progress
      logic        stb;                   // transfer strobe
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic [15:0] dat;                   // read data
      logic        ack;                   // transfer done
   } wb_rsp_t;

   // address seen by the memory slave
   typedef struct packed {
      logic [14-`WBS_MEM_AW:0] region;    // must be 0 for ram
      logic [`WBS_MEM_AW-1:0]  word;      // ram word index
      logic                    lane;      // byte within word
   } wb_adr_mem_t;

   // address seen by the i/o slave
   typedef struct packed {
      logic [12:0] page;                  // compared with io page
      logic [1:0]  idx;                   // register index
      logic        lane;                  // byte within word
   } wb_adr_io_t;

   // one bus address, two decodings
   typedef union packed {
      wb_adr_mem_t mem;
      wb_adr_io_t  io;
   } wb_adr_u;

endpackage

// File: logic/wbs_defines.svh
// wishbone slave subsystem parameters
// address map, ram size and display scan rate

`ifndef WBS_DEFINES_SVH
`define WBS_DEFINES_SVH

// ram word address width, 8K words of 16 bits
// the ram sits in region 0, bytes 0x0000..0x3FFF
`define WBS_MEM_AW 13

// upper 13 address bits of the i/o page
// 0xFFC0 >> 3, covers 0xFFC0..0xFFC7
// index 0 disp0, 1 disp1, 2 buttons, 3 reserved
`define WBS_IO_PAGE 13'h1FF8

// wb_clk cycles per digit step of the scan driver
// board value would be near one millisecond, small here for simulation
`define WBS_SCAN_DIV 8

// number of multiplexed seven segment digits
// digits 0..3 show display bytes, the rest stay blank
`define WBS_DIGITS 6

`endif
